// ==== src/mmu_cfg.svh ====
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// address and field widths
`define MMU_VA_W        32
`define MMU_ASID_W      8
`define MMU_VPN2_W      19   // one tag covers an even/odd page pair
`define MMU_PFN_W       20
`define MMU_OFS_W       12   // 4 KB pages

// tlb geometry
`define MMU_TLB_N       16
`define MMU_IDX_W       4

// top three va bits of the unmapped segments
`define MMU_SEG_KSEG0   3'b100
`define MMU_SEG_KSEG1   3'b101

// page cache attribute
`define MMU_C_UNCACHED  3'd2

// response exception codes
`define MMU_EXC_NONE    2'd0
`define MMU_EXC_REFILL  2'd1
`define MMU_EXC_INVALID 2'd2
`define MMU_EXC_MOD     2'd3

`endif

// ==== src/mmu_pkg.sv ====
`default_nettype none
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic                   odd_page;   // picks even or odd half of the pair
        logic [`MMU_OFS_W-1:0]  offset;
    } page_view_t;

    typedef struct packed {
        logic [2:0]             seg;
        logic [`MMU_VA_W-4:0]   low;
    } seg_view_t;

    // one virtual address, read as tlb fields or as segment bits
    typedef union packed {
        page_view_t page;
        seg_view_t  segment;
    } vaddr_u;

endpackage

`default_nettype wire

// ==== src/tlb_match_if.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

// result of one tlb search, already narrowed to the selected page
interface tlb_match_if;

    logic                  hit;
    logic [`MMU_PFN_W-1:0] pfn;
    logic [2:0]            cattr;
    logic                  dirty;
    logic                  valid;

    modport array   (output hit, pfn, cattr, dirty, valid);

    modport resolve (input  hit, pfn, cattr, dirty, valid);

endinterface

`default_nettype wire

// ==== src/seg_map.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

// kernel segment decode
// kseg0 and kseg1 bypass the tlb and alias the low 512 MB of physical space
module seg_map (
    input  mmu_pkg::vaddr_u         va,
    output logic                    mapped,
    output logic                    seg_uncached,
    output logic [`MMU_VA_W-1:0]    direct_paddr
);

    logic in_kseg0;
    logic in_kseg1;

    always_comb begin
        in_kseg0 = (va.segment.seg == `MMU_SEG_KSEG0);
        in_kseg1 = (va.segment.seg == `MMU_SEG_KSEG1);
    end

    // anything outside kseg0/kseg1 goes through the tlb
    assign mapped       = !(in_kseg0 || in_kseg1);
    assign seg_uncached = in_kseg1;

    // strip the segment bits
    assign direct_paddr = {3'b000, va.segment.low};

endmodule

`default_nettype wire

// ==== src/tlb_array.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

module tlb_array (
    input  wire                     aclk,
    input  wire                     arst_n,
    input  mmu_pkg::vaddr_u         va,
    input  wire [`MMU_ASID_W-1:0]   asid,
    input  wire                     tlb_we,
    input  wire [`MMU_IDX_W-1:0]    tlb_windex,
    input  wire [`MMU_VPN2_W-1:0]   tlb_wvpn2,
    input  wire [`MMU_ASID_W-1:0]   tlb_wasid,
    input  wire                     tlb_wg,
    input  wire [`MMU_PFN_W-1:0]    tlb_wpfn0,
    input  wire [2:0]               tlb_wc0,
    input  wire                     tlb_wd0,
    input  wire                     tlb_wv0,
    input  wire [`MMU_PFN_W-1:0]    tlb_wpfn1,
    input  wire [2:0]               tlb_wc1,
    input  wire                     tlb_wd1,
    input  wire                     tlb_wv1,
    tlb_match_if.array              match
);

    logic [`MMU_VPN2_W-1:0] e_vpn2 [`MMU_TLB_N];
    logic [`MMU_ASID_W-1:0] e_asid [`MMU_TLB_N];
    logic                   e_g    [`MMU_TLB_N];
    logic [`MMU_PFN_W-1:0]  e_pfn0 [`MMU_TLB_N];
    logic [2:0]             e_c0   [`MMU_TLB_N];
    logic                   e_d0   [`MMU_TLB_N];
    logic                   e_v0   [`MMU_TLB_N];
    logic [`MMU_PFN_W-1:0]  e_pfn1 [`MMU_TLB_N];
    logic [2:0]             e_c1   [`MMU_TLB_N];
    logic                   e_d1   [`MMU_TLB_N];
    logic                   e_v1   [`MMU_TLB_N];

    logic [`MMU_TLB_N-1:0]  entry_match;
    logic                   hit_any;
    logic [`MMU_IDX_W-1:0]  hit_idx;

    // indexed write, plays the part of tlbwi
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MMU_TLB_N; i++) begin
                e_vpn2[i] <= '0;
                e_asid[i] <= '0;
                e_g[i]    <= 1'b0;
                e_pfn0[i] <= '0;
                e_c0[i]   <= '0;
                e_d0[i]   <= 1'b0;
                e_v0[i]   <= 1'b0;
                e_pfn1[i] <= '0;
                e_c1[i]   <= '0;
                e_d1[i]   <= 1'b0;
                e_v1[i]   <= 1'b0;
            end
        end else if (tlb_we) begin
            e_vpn2[tlb_windex] <= tlb_wvpn2;
            e_asid[tlb_windex] <= tlb_wasid;
            e_g[tlb_windex]    <= tlb_wg;
            e_pfn0[tlb_windex] <= tlb_wpfn0;
            e_c0[tlb_windex]   <= tlb_wc0;
            e_d0[tlb_windex]   <= tlb_wd0;
            e_v0[tlb_windex]   <= tlb_wv0;
            e_pfn1[tlb_windex] <= tlb_wpfn1;
            e_c1[tlb_windex]   <= tlb_wc1;
            e_d1[tlb_windex]   <= tlb_wd1;
            e_v1[tlb_windex]   <= tlb_wv1;
        end
    end

    // fully associative compare
    always_comb begin
        for (int i = 0; i < `MMU_TLB_N; i++) begin
            entry_match[i] = (e_vpn2[i] == va.page.vpn2) &&
                             (e_g[i] || (e_asid[i] == asid));
        end
    end

    // scan downwards so the lowest matching index is kept
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = `MMU_TLB_N - 1; i >= 0; i--) begin
            if (entry_match[i]) begin
                hit_any = 1'b1;
                hit_idx = i[`MMU_IDX_W-1:0];
            end
        end
    end

    assign match.hit   = hit_any;
    assign match.pfn   = va.page.odd_page ? e_pfn1[hit_idx] : e_pfn0[hit_idx];
    assign match.cattr = va.page.odd_page ? e_c1[hit_idx]   : e_c0[hit_idx];
    assign match.dirty = va.page.odd_page ? e_d1[hit_idx]   : e_d0[hit_idx];
    assign match.valid = va.page.odd_page ? e_v1[hit_idx]   : e_v0[hit_idx];

endmodule

`default_nettype wire

// ==== src/xlat_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

module xlat_resolve (
    input  wire                     aclk,
    input  wire                     arst_n,
    input  wire                     xlat_req,
    input  wire                     is_store,
    input  wire                     mapped,
    input  wire                     seg_uncached,
    input  wire [`MMU_VA_W-1:0]     direct_paddr,
    input  mmu_pkg::vaddr_u         va,
    tlb_match_if.resolve            match,
    output logic                    resp_valid,
    output logic [`MMU_VA_W-1:0]    paddr,
    output logic                    uncached,
    output logic [1:0]              exc_code
);

    logic [`MMU_VA_W-1:0] nxt_paddr;
    logic                 nxt_uncached;
    logic [1:0]           nxt_exc;

    always_comb begin
        nxt_paddr    = direct_paddr;
        nxt_uncached = seg_uncached;
        nxt_exc      = `MMU_EXC_NONE;
        if (mapped) begin
            nxt_paddr    = {match.pfn, va.page.offset};
            nxt_uncached = (match.cattr == `MMU_C_UNCACHED);
            // priority: refill, invalid, modified
            if (!match.hit) begin
                nxt_exc = `MMU_EXC_REFILL;
            end else if (!match.valid) begin
                nxt_exc = `MMU_EXC_INVALID;
            end else if (is_store && !match.dirty) begin
                nxt_exc = `MMU_EXC_MOD;   // write to clean page
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= xlat_req;   // one cycle behind the strobe
        end
    end

    always_ff @(posedge aclk) begin
        if (xlat_req) begin
            paddr    <= nxt_paddr;
            uncached <= nxt_uncached;
            exc_code <= nxt_exc;
        end
    end

endmodule

`default_nettype wire

// ==== src/mmu_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

module mmu_top (
    input  wire                     aclk,
    input  wire                     arst_n,
    // translation request
    input  wire                     xlat_req,
    input  wire [`MMU_VA_W-1:0]     vaddr,
    input  wire [`MMU_ASID_W-1:0]   asid,
    input  wire                     is_store,
    // tlb entry write
    input  wire                     tlb_we,
    input  wire [`MMU_IDX_W-1:0]    tlb_windex,
    input  wire [`MMU_VPN2_W-1:0]   tlb_wvpn2,
    input  wire [`MMU_ASID_W-1:0]   tlb_wasid,
    input  wire                     tlb_wg,
    input  wire [`MMU_PFN_W-1:0]    tlb_wpfn0,
    input  wire [2:0]               tlb_wc0,
    input  wire                     tlb_wd0,
    input  wire                     tlb_wv0,
    input  wire [`MMU_PFN_W-1:0]    tlb_wpfn1,
    input  wire [2:0]               tlb_wc1,
    input  wire                     tlb_wd1,
    input  wire                     tlb_wv1,
    // response, one cycle after the request
    output logic                    resp_valid,
    output logic [`MMU_VA_W-1:0]    paddr,
    output logic                    uncached,
    output logic [1:0]              exc_code
);

    mmu_pkg::vaddr_u      va;
    logic                 mapped;
    logic                 seg_uncached;
    logic [`MMU_VA_W-1:0] direct_paddr;

    tlb_match_if match_bus ();

    assign va = vaddr;

    seg_map u_seg_map (
        .va           (va),
        .mapped       (mapped),
        .seg_uncached (seg_uncached),
        .direct_paddr (direct_paddr)
    );

    tlb_array u_tlb_array (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .va         (va),
        .asid       (asid),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wvpn2  (tlb_wvpn2),
        .tlb_wasid  (tlb_wasid),
        .tlb_wg     (tlb_wg),
        .tlb_wpfn0  (tlb_wpfn0),
        .tlb_wc0    (tlb_wc0),
        .tlb_wd0    (tlb_wd0),
        .tlb_wv0    (tlb_wv0),
        .tlb_wpfn1  (tlb_wpfn1),
        .tlb_wc1    (tlb_wc1),
        .tlb_wd1    (tlb_wd1),
        .tlb_wv1    (tlb_wv1),
        .match      (match_bus)
    );

    xlat_resolve u_xlat_resolve (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .xlat_req     (xlat_req),
        .is_store     (is_store),
        .mapped       (mapped),
        .seg_uncached (seg_uncached),
        .direct_paddr (direct_paddr),
        .va           (va),
        .match        (match_bus),
        .resp_valid   (resp_valid),
        .paddr        (paddr),
        .uncached     (uncached),
        .exc_code     (exc_code)
    );

endmodule

`default_nettype wire

// ==== testbench/mmu_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

module mmu_asserts (
    input wire       aclk,
    input wire       arst_n,
    input wire       xlat_req,
    input wire       mapped,
    input wire       resp_valid,
    input wire [1:0] exc_code
);

    // response pulse follows the strobe by exactly one cycle
    a_resp_after_req: assert property (@(posedge aclk) disable iff (!arst_n)
        xlat_req |=> resp_valid)
        else $error("resp_valid missing one cycle after xlat_req");

    a_no_extra_resp: assert property (@(posedge aclk) disable iff (!arst_n)
        !xlat_req |=> !resp_valid)
        else $error("resp_valid raised without a request");

    // kseg0/kseg1 never fault
    a_unmapped_no_exc: assert property (@(posedge aclk) disable iff (!arst_n)
        (xlat_req && !mapped) |=> (exc_code == `MMU_EXC_NONE))
        else $error("exception code on an unmapped request");

endmodule

bind mmu_top mmu_asserts u_asserts (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .xlat_req   (xlat_req),
    .mapped     (mapped),
    .resp_valid (resp_valid),
    .exc_code   (exc_code)
);

`default_nettype wire

// ==== testbench/mmu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mmu_cfg.svh"

module mmu_tb;

    localparam int RST_CYCLES = 5;
    localparam int N_OPS      = 26;   // requests plus tlb writes over all tests
    localparam int LIMIT_NS   = (N_OPS + RST_CYCLES) * 40 * 4;

    logic                    aclk = 1'b0;
    logic                    arst_n;
    logic                    xlat_req;
    logic                    is_store;
    logic [`MMU_VA_W-1:0]    vaddr;
    logic [`MMU_ASID_W-1:0]  asid;
    logic                    tlb_we;
    logic [`MMU_IDX_W-1:0]   tlb_windex;
    logic [`MMU_VPN2_W-1:0]  tlb_wvpn2;
    logic [`MMU_ASID_W-1:0]  tlb_wasid;
    logic                    tlb_wg;
    logic [`MMU_PFN_W-1:0]   tlb_wpfn0;
    logic [`MMU_PFN_W-1:0]   tlb_wpfn1;
    logic [2:0]              tlb_wc0;
    logic [2:0]              tlb_wc1;
    logic                    tlb_wd0;
    logic                    tlb_wv0;
    logic                    tlb_wd1;
    logic                    tlb_wv1;
    logic                    resp_valid;
    logic [`MMU_VA_W-1:0]    paddr;
    logic                    uncached;
    logic [1:0]              exc_code;

    int errors = 0;
    int checks = 0;
    int seed   = 88;

    mmu_top UUT (.*);

    always #20 aclk = ~aclk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called on the falling edge after the capture edge
    task automatic expect_resp(input logic [31:0] exp_pa, input logic exp_unc,
                               input logic [1:0] exp_exc, input logic chk_addr);
        if (resp_valid !== 1'b1) begin
            errors++;
            $display("no response one cycle after the request, t=%0t", $time);
        end else begin
            check_val("exc_code", 32'(exc_code), 32'(exp_exc));
            if (chk_addr) begin
                check_val("paddr", paddr, exp_pa);
                check_val("uncached", 32'(uncached), 32'(exp_unc));
            end
        end
    endtask

    // page = {pfn, c, d, v}
    task automatic tlb_write(input logic [3:0] idx, input logic [18:0] vpn2,
                             input logic [7:0] id, input logic g,
                             input logic [24:0] p0, input logic [24:0] p1);
        @(posedge aclk);
        tlb_we     <= 1'b1;
        tlb_windex <= idx;
        tlb_wvpn2  <= vpn2;
        tlb_wasid  <= id;
        tlb_wg     <= g;
        {tlb_wpfn0, tlb_wc0, tlb_wd0, tlb_wv0} <= p0;
        {tlb_wpfn1, tlb_wc1, tlb_wd1, tlb_wv1} <= p1;
    endtask

    task automatic translate(input logic [31:0] va, input logic [7:0] id, input logic st,
                             input logic [31:0] exp_pa, input logic exp_unc,
                             input logic [1:0] exp_exc, input logic chk_addr);
        @(posedge aclk);
        tlb_we   <= 1'b0;   // a pending write lands on this edge
        xlat_req <= 1'b1;
        vaddr    <= va;
        asid     <= id;
        is_store <= st;
        @(posedge aclk);
        xlat_req <= 1'b0;
        @(negedge aclk);
        expect_resp(exp_pa, exp_unc, exp_exc, chk_addr);
    endtask

    task automatic pulse_timing();
        repeat (3) begin
            @(negedge aclk);
            check_val("resp_valid", 32'(resp_valid), 32'd0);
        end
        translate(32'h8000_1234, 8'h00, 1'b0, 32'h0000_1234, 1'b0, `MMU_EXC_NONE, 1'b1);
        @(negedge aclk);
        check_val("resp_valid", 32'(resp_valid), 32'd0);   // single-cycle pulse
        @(posedge aclk);
        xlat_req <= 1'b1;
        vaddr    <= 32'h8000_1234;
        @(posedge aclk);
        vaddr    <= 32'hA123_4560;   // second request back to back
        @(negedge aclk);
        expect_resp(32'h0000_1234, 1'b0, `MMU_EXC_NONE, 1'b1);
        @(posedge aclk);
        xlat_req <= 1'b0;
        @(negedge aclk);
        expect_resp(32'h0123_4560, 1'b1, `MMU_EXC_NONE, 1'b1);
        @(negedge aclk);
        check_val("resp_valid", 32'(resp_valid), 32'd0);
    endtask

    task automatic unmapped_segments();
        logic [31:0] r;
        logic [31:0] va;
        for (int i = 0; i < 8; i++) begin
            r  = $random(seed);
            va = {(i % 2 == 0) ? `MMU_SEG_KSEG0 : `MMU_SEG_KSEG1, r[28:0]};
            translate(va, r[7:0], r[29], {3'b000, r[28:0]}, (i % 2 == 1),
                      `MMU_EXC_NONE, 1'b1);
        end
    endtask

    task automatic mapped_pages();
        tlb_write(4'd3, 19'h12345, 8'h21, 1'b0, {20'hABCDE, 3'd3, 1'b1, 1'b1},
                  {20'h13579, 3'd2, 1'b1, 1'b1});
        translate({19'h12345, 1'b0, 12'h5A4}, 8'h21, 1'b0, {20'hABCDE, 12'h5A4}, 1'b0,
                  `MMU_EXC_NONE, 1'b1);
        translate({19'h12345, 1'b1, 12'h0F0}, 8'h21, 1'b1, {20'h13579, 12'h0F0}, 1'b1,
                  `MMU_EXC_NONE, 1'b1);
    endtask

    task automatic asid_and_vpn_misses();
        tlb_write(4'd5, 19'h0A0A0, 8'h10, 1'b0, {20'h11111, 3'd3, 1'b1, 1'b1},
                  {20'h22222, 3'd3, 1'b1, 1'b1});
        tlb_write(4'd6, 19'h0B0B0, 8'h10, 1'b1, {20'h33333, 3'd3, 1'b1, 1'b1},
                  {20'h44444, 3'd3, 1'b1, 1'b1});
        translate({19'h0A0A0, 1'b0, 12'h010}, 8'h11, 1'b0, 32'd0, 1'b0,
                  `MMU_EXC_REFILL, 1'b0);
        translate({19'h0B0B0, 1'b1, 12'h020}, 8'h77, 1'b0, {20'h44444, 12'h020}, 1'b0,
                  `MMU_EXC_NONE, 1'b1);   // global entry matches any asid
        translate({19'h2F00F, 1'b0, 12'h030}, 8'h10, 1'b0, 32'd0, 1'b0,
                  `MMU_EXC_REFILL, 1'b0);
    endtask

    task automatic page_faults();
        tlb_write(4'd8, 19'h04444, 8'h30, 1'b0, {20'h55555, 3'd3, 1'b1, 1'b0},
                  {20'h66666, 3'd3, 1'b0, 1'b1});
        translate({19'h04444, 1'b0, 12'h100}, 8'h30, 1'b0, 32'd0, 1'b0,
                  `MMU_EXC_INVALID, 1'b0);
        translate({19'h04444, 1'b1, 12'h200}, 8'h30, 1'b1, 32'd0, 1'b0,
                  `MMU_EXC_MOD, 1'b0);
        translate({19'h04444, 1'b1, 12'h200}, 8'h30, 1'b0, {20'h66666, 12'h200}, 1'b0,
                  `MMU_EXC_NONE, 1'b1);
    endtask

    task automatic entry_rewrite();
        tlb_write(4'd3, 19'h12345, 8'h21, 1'b0, {20'h0F0F0, 3'd2, 1'b1, 1'b1},
                  {20'h0E0E0, 3'd3, 1'b1, 1'b1});
        translate({19'h12345, 1'b0, 12'h444}, 8'h21, 1'b0, {20'h0F0F0, 12'h444}, 1'b1,
                  `MMU_EXC_NONE, 1'b1);
        translate({19'h12345, 1'b1, 12'h888}, 8'h21, 1'b0, {20'h0E0E0, 12'h888}, 1'b0,
                  `MMU_EXC_NONE, 1'b1);
    endtask

    initial begin
        arst_n     = 1'b0;
        xlat_req   = 1'b0;
        is_store   = 1'b0;
        vaddr      = '0;
        asid       = '0;
        tlb_we     = 1'b0;
        tlb_windex = '0;
        tlb_wvpn2  = '0;
        tlb_wasid  = '0;
        tlb_wg     = 1'b0;
        {tlb_wpfn0, tlb_wc0, tlb_wd0, tlb_wv0} = 25'd0;
        {tlb_wpfn1, tlb_wc1, tlb_wd1, tlb_wv1} = 25'd0;
        repeat (RST_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
        pulse_timing();
        unmapped_segments();
        mapped_pages();
        asid_and_vpn_misses();
        page_faults();
        entry_rewrite();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: tests still running after %0d ns", LIMIT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/mmu_pkg.sv
src/tlb_match_if.sv
src/seg_map.sv
src/tlb_array.sv
src/xlat_resolve.sv
src/mmu_top.sv
testbench/mmu_asserts.sv
testbench/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module mmu_tb -o mmu_sim
./obj_dir/mmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
